// File: source/flit_pkg.sv
// ##########################################################
// flit format shared by every block that touches link data
// import where the payload layout or the head fields are read
// ##########################################################

`default_nettype none

package flit_pkg;

   // payload width of one flit on a sub-channel
   localparam int FLIT_DATA_W = 16;

   typedef logic [FLIT_DATA_W-1:0] flit_data_t;   // raw flit payload

   // the head flit carries its destination port in the low data bits
   localparam int DEST_W = 3;

   typedef logic [DEST_W-1:0] dest_t;             // destination field of a head

   // one flit as it travels on a link, 17 bits
   typedef struct packed {
      logic       eof;                            // last flit of the frame
      flit_data_t data;                           // head holds dest in [2:0]
   } flit_t;

endpackage : flit_pkg

`default_nettype wire

// File: source/router_pkg.sv
// ##########################################################
// router structure: port and sub-channel counts, channel ids
// and the connection record kept by the switch allocator
// ##########################################################

`default_nettype none

package router_pkg;

   localparam int N_PORTS = 4;                    // ports of one router
   localparam int N_SUBC  = 2;                    // sdm slices per port
   localparam int N_CHAN  = N_PORTS * N_SUBC;     // flat channel count

   typedef logic [$clog2(N_PORTS)-1:0] port_id_t; // port number
   typedef logic [$clog2(N_CHAN)-1:0]  chan_id_t; // port * N_SUBC + subc

   // one end of a path through the crossbar
   typedef struct packed {
      logic     busy;                             // path is held
      chan_id_t chan;                             // channel at the other end
   } conn_t;

   // sub-channel controller states
   typedef enum logic [1:0] {
      SC_IDLE = 2'd0,                             // waiting for a head flit
      SC_REQ  = 2'd1,                             // asking the allocator
      SC_FWD  = 2'd2,                             // path held, flits pass
      SC_DROP = 2'd3                              // bad route, ack and discard
   } subc_state_e;

endpackage : router_pkg

`default_nettype wire

// File: source/route_decode.sv
// ##########################################################
// decode stage: pulls the destination port out of a head flit
// and flags destinations that do not exist in this router
// one instance per input channel, purely combinational
// ##########################################################

`default_nettype none

module route_decode (
   input  flit_pkg::flit_t      flit,      // flit currently offered upstream
   output router_pkg::port_id_t dest_port, // port taken from the head
   output logic                 rt_err     // destination out of range
);
   import flit_pkg::*;
   import router_pkg::*;

   dest_t dest;                            // raw destination field

   // the field is only meaningful on a head flit, the controller
   // decides when to look at it
   assign dest = flit.data[DEST_W-1:0];

   // keep the low bits as the port number
   assign dest_port = port_id_t'(dest);

   // anything at or above the port count has nowhere to go
   assign rt_err = (dest > dest_t'(N_PORTS - 1));

endmodule : route_decode

`default_nettype wire

// File: source/subc_ctl.sv
// ##########################################################
// execute stage controller for one input sub-channel
// requests an output port, holds it for the frame, releases
// it after the eof ack, or drops frames with a bad route
// ##########################################################

`default_nettype none

module subc_ctl (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 valid,        // upstream flit present
   input  flit_pkg::flit_t      flit,         // upstream flit
   input  router_pkg::port_id_t dest_port,    // from route decoder
   input  logic                 rt_err,       // invalid destination
   input  logic                 grant,        // allocator has a path for us
   input  logic                 ack,          // out_ack routed back from the path
   output logic                 req,          // request level to allocator
   output router_pkg::port_id_t req_port,     // port being asked for
   output logic                 release_conn, // eof flit accepted, free path
   output logic                 drop_ack      // ack pulse for a dropped flit
);
   import router_pkg::*;

   subc_state_e state_q;
   subc_state_e state_d;
   port_id_t    port_q;                       // latched destination port
   logic        connected;                    // path granted and usable
   logic        drop_ack_d;

   // the grant can land while still in SC_REQ, the crossbar already
   // passes flits then, so count that cycle as connected too
   assign connected    = (state_q == SC_FWD) || ((state_q == SC_REQ) && grant);
   assign release_conn = connected && ack && flit.eof;

   assign req      = (state_q == SC_REQ) && !grant; // drop request once held
   assign req_port = port_q;

   always_comb begin
      state_d = state_q;
      unique case (state_q)
         SC_IDLE: begin
            if (valid) begin                  // head flit arrived
               state_d = rt_err ? SC_DROP : SC_REQ;
            end
         end
         SC_REQ: begin
            if (grant) begin
               state_d = release_conn ? SC_IDLE : SC_FWD; // single flit frame
            end
         end
         SC_FWD: begin
            if (release_conn) state_d = SC_IDLE;
         end
         SC_DROP: begin
            if (drop_ack && flit.eof) state_d = SC_IDLE; // eof acked
         end
         default: state_d = SC_IDLE;
      endcase
   end

   // one pulse per flit, low again on the edge after each pulse so the
   // sender can swap in the next flit
   assign drop_ack_d = ((state_q == SC_IDLE) && valid && rt_err) ||
                       ((state_q == SC_DROP) && valid && !drop_ack);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q  <= SC_IDLE;
         drop_ack <= 1'b0;
      end else begin
         state_q  <= state_d;
         drop_ack <= drop_ack_d;
      end
   end

   always_ff @(posedge clk) begin
      if ((state_q == SC_IDLE) && valid) port_q <= dest_port; // capture on head
   end

endmodule : subc_ctl

`default_nettype wire

// File: source/switch_alloc.sv
// ##########################################################
// execute stage switch allocator with rotating priority
// maps each request onto a free sub-channel of the wanted port
// and keeps the in and out connection tables for the crossbar
// ##########################################################

`default_nettype none

module switch_alloc (
   input  logic                                    clk,
   input  logic                                    rst_n,
   input  logic [router_pkg::N_CHAN-1:0]           req,          // per input
   input  router_pkg::port_id_t [router_pkg::N_CHAN-1:0] req_port, // wanted port
   input  logic [router_pkg::N_CHAN-1:0]           release_conn, // eof accepted
   output router_pkg::conn_t [router_pkg::N_CHAN-1:0]    in_conn,  // input -> output
   output router_pkg::conn_t [router_pkg::N_CHAN-1:0]    out_conn  // output -> input
);
   import router_pkg::*;

   conn_t    [N_CHAN-1:0]  in_d;
   conn_t    [N_CHAN-1:0]  out_d;
   chan_id_t [N_PORTS-1:0] ptr_q;          // first input to look at, per port
   chan_id_t [N_PORTS-1:0] ptr_d;

   always_comb begin : alloc
      logic [N_CHAN-1:0] taken;            // outputs handed out this cycle
      chan_id_t          idx;              // input under consideration
      chan_id_t          oc;               // candidate output channel
      logic              placed;

      in_d   = in_conn;
      out_d  = out_conn;
      ptr_d  = ptr_q;
      taken  = '0;
      idx    = '0;
      oc     = '0;
      placed = 1'b0;

      // releases clear both ends, the freed output is only offered
      // again after this edge
      for (int i = 0; i < N_CHAN; i++) begin
         if (release_conn[i] && in_conn[i].busy) begin
            out_d[in_conn[i].chan] = '0;
            in_d[i]                = '0;
         end
      end

      for (int p = 0; p < N_PORTS; p++) begin
         for (int k = 0; k < N_CHAN; k++) begin
            idx = ptr_q[p] + chan_id_t'(k);          // wraps around the inputs
            if (req[idx] && (req_port[idx] == port_id_t'(p)) && !in_conn[idx].busy) begin
               placed = 1'b0;
               for (int s = 0; s < N_SUBC; s++) begin
                  oc = chan_id_t'(p * N_SUBC + s);   // lowest free slice first
                  if (!placed && !out_conn[oc].busy && !taken[oc]) begin
                     taken[oc] = 1'b1;
                     placed    = 1'b1;
                     in_d[idx] = '{busy: 1'b1, chan: oc};
                     out_d[oc] = '{busy: 1'b1, chan: idx};
                     ptr_d[p]  = idx + chan_id_t'(1); // winner drops to last
                  end
               end
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         in_conn  <= '0;
         out_conn <= '0;
         ptr_q    <= '0;
      end else begin
         in_conn  <= in_d;
         out_conn <= out_d;
         ptr_q    <= ptr_d;
      end
   end

endmodule : switch_alloc

`default_nettype wire

// File: source/crossbar.sv
// ##########################################################
// result stage crossbar: flits go forward along granted paths
// and acks come back, merged with the drop acks of bad frames
// ##########################################################

`default_nettype none

module crossbar (
   input  flit_pkg::flit_t   [router_pkg::N_CHAN-1:0] in_flit,
   input  logic              [router_pkg::N_CHAN-1:0] in_valid,
   input  router_pkg::conn_t [router_pkg::N_CHAN-1:0] in_conn,  // per input
   input  router_pkg::conn_t [router_pkg::N_CHAN-1:0] out_conn, // per output
   input  logic              [router_pkg::N_CHAN-1:0] out_ack,  // downstream acks
   input  logic              [router_pkg::N_CHAN-1:0] drop_ack, // from controllers
   output flit_pkg::flit_t   [router_pkg::N_CHAN-1:0] out_flit,
   output logic              [router_pkg::N_CHAN-1:0] out_valid,
   output logic              [router_pkg::N_CHAN-1:0] in_ack,   // to upstream
   output logic              [router_pkg::N_CHAN-1:0] fwd_ack   // to controllers
);
   import router_pkg::*;

   // forward data, an unowned output stays quiet
   always_comb begin
      for (int o = 0; o < N_CHAN; o++) begin
         if (out_conn[o].busy) begin
            out_flit[o]  = in_flit[out_conn[o].chan];
            out_valid[o] = in_valid[out_conn[o].chan];
         end else begin
            out_flit[o]  = '0;
            out_valid[o] = 1'b0;
         end
      end
   end

   // backward acks, pick the ack of the output this input holds
   always_comb begin
      for (int i = 0; i < N_CHAN; i++) begin
         fwd_ack[i] = in_conn[i].busy & out_ack[in_conn[i].chan];
         in_ack[i]  = fwd_ack[i] | drop_ack[i];     // at most one is ever high
      end
   end

endmodule : crossbar

`default_nettype wire

// File: source/sdm_router.sv
// ##########################################################
// top of the synchronous sdm wormhole router, 4 ports x 2
// sub-channels, decode / execute / result stages wired here
// ##########################################################

`default_nettype none

module sdm_router (
   input  logic                                      clk,
   input  logic                                      rst_n,
   input  flit_pkg::flit_t [router_pkg::N_CHAN-1:0]  in_flit,   // upstream flits
   input  logic            [router_pkg::N_CHAN-1:0]  in_valid,
   output logic            [router_pkg::N_CHAN-1:0]  in_ack,    // one-cycle pulses
   output flit_pkg::flit_t [router_pkg::N_CHAN-1:0]  out_flit,  // downstream flits
   output logic            [router_pkg::N_CHAN-1:0]  out_valid,
   input  logic            [router_pkg::N_CHAN-1:0]  out_ack
);
   import router_pkg::*;

   port_id_t [N_CHAN-1:0] dest_port;       // decoded destination
   logic     [N_CHAN-1:0] rt_err;
   logic     [N_CHAN-1:0] req;
   port_id_t [N_CHAN-1:0] req_port;
   logic     [N_CHAN-1:0] release_conn;
   logic     [N_CHAN-1:0] drop_ack;
   logic     [N_CHAN-1:0] fwd_ack;         // out_ack seen by each input
   conn_t    [N_CHAN-1:0] in_conn;
   conn_t    [N_CHAN-1:0] out_conn;

   for (genvar i = 0; i < N_CHAN; i++) begin : g_chan
      route_decode i_route_decode (
         .flit      (in_flit[i]),
         .dest_port (dest_port[i]),
         .rt_err    (rt_err[i])
      );

      subc_ctl i_subc_ctl (
         .clk          (clk),
         .rst_n        (rst_n),
         .valid        (in_valid[i]),
         .flit         (in_flit[i]),
         .dest_port    (dest_port[i]),
         .rt_err       (rt_err[i]),
         .grant        (in_conn[i].busy),   // table entry doubles as grant
         .ack          (fwd_ack[i]),
         .req          (req[i]),
         .req_port     (req_port[i]),
         .release_conn (release_conn[i]),
         .drop_ack     (drop_ack[i])
      );
   end

   switch_alloc i_switch_alloc (
      .clk          (clk),
      .rst_n        (rst_n),
      .req          (req),
      .req_port     (req_port),
      .release_conn (release_conn),
      .in_conn      (in_conn),
      .out_conn     (out_conn)
   );

   crossbar i_crossbar (
      .in_flit   (in_flit),
      .in_valid  (in_valid),
      .in_conn   (in_conn),
      .out_conn  (out_conn),
      .out_ack   (out_ack),
      .drop_ack  (drop_ack),
      .out_flit  (out_flit),
      .out_valid (out_valid),
      .in_ack    (in_ack),
      .fwd_ack   (fwd_ack)
   );

endmodule : sdm_router

`default_nettype wire

// File: tests/tb_sdm_router.sv
// ##########################################################
// testbench for the sdm router: random frames on every input,
// random downstream ack delays, per-source queues of expected
// flits checked on each output transfer; started by run.sh
// ##########################################################

`default_nettype none

module tb_sdm_router;
   timeunit 1ns;
   timeprecision 100ps;

   import flit_pkg::*;
   import router_pkg::*;

   localparam int N_FRAMES  = 12;                       // frames sent by each source
   localparam int LIMIT_CYC = N_FRAMES * N_CHAN * 60 + 200;

   logic               clk;
   logic               rst_n;
   flit_t [N_CHAN-1:0] in_flit;
   logic  [N_CHAN-1:0] in_valid;
   logic  [N_CHAN-1:0] in_ack;
   flit_t [N_CHAN-1:0] out_flit;
   logic  [N_CHAN-1:0] out_valid;
   logic  [N_CHAN-1:0] out_ack;

   int                 seed = 32'he9ec;
   flit_t              tx_q  [N_CHAN][$];               // flits still to offer, per source
   flit_t              exp_q [N_CHAN][$];               // flits due downstream, per source
   int                 frames_left [N_CHAN];
   int                 gap         [N_CHAN];            // idle cycles before next frame
   logic [7:0]         seq         [N_CHAN];
   int                 owner       [N_CHAN];            // source on each output, -1 if none
   port_id_t           owner_port  [N_CHAN];            // port the owner asked for
   int                 wait_cnt    [N_CHAN];            // cycles left before acking
   logic               armed       [N_CHAN];
   logic               prev_hold   [N_CHAN];            // valid and unacked last cycle
   flit_t              prev_flit   [N_CHAN];
   logic               last_in_ack [N_CHAN];            // in_ack seen last cycle
   logic  [N_CHAN-1:0] ack_nxt;
   logic  [N_CHAN-1:0] valid_nxt;
   flit_t [N_CHAN-1:0] flit_nxt;
   int                 sent_frames = 0;                 // valid frames only
   int                 rcvd_frames = 0;

   sdm_router i_sdm_router (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_flit   (in_flit),
      .in_valid  (in_valid),
      .in_ack    (in_ack),
      .out_flit  (out_flit),
      .out_valid (out_valid),
      .out_ack   (out_ack)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("*** TEST FAILED ***");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_flit(input string name, input flit_t exp, input flit_t act);
      if (act !== exp) fail_run($sformatf("ERR %s expected %05h actual %05h", name, exp, act));
   endtask

   task automatic check_port(input string name, input port_id_t exp, input port_id_t act);
      if (act !== exp) fail_run($sformatf("ERR %s expected %0d actual %0d", name, exp, act));
   endtask

   task automatic check_idle(input string name, input logic exp, input logic act);
      if (act !== exp) fail_run($sformatf("ERR %s expected %b actual %b", name, exp, act));
   endtask

   function automatic int rnd(input int n);            // 0 .. n-1 from the seeded stream
      int r;
      r = $random(seed);
      return (r & 32'h7fff_ffff) % n;
   endfunction

   task automatic make_frame(input int src);
      logic  is_bad;
      dest_t dest;
      int    len;
      flit_t f;
      is_bad = (rnd(4) == 0);                           // about a quarter go nowhere
      dest   = is_bad ? dest_t'(4 + rnd(4)) : dest_t'(rnd(4));
      len    = 1 + rnd(5);
      for (int k = 0; k < len; k++) begin
         f.eof  = (k == len - 1);
         f.data = (k == 0) ? {seq[src], 1'b0, chan_id_t'(src), 1'b0, dest}
                           : flit_data_t'(rnd(65536));
         tx_q[src].push_back(f);
         if (!is_bad) exp_q[src].push_back(f);
      end
      if (!is_bad) sent_frames++;
      seq[src] = seq[src] + 8'd1;
   endtask

   task automatic accept_flit(input int o);
      flit_t f;
      flit_t e;
      int    src;
      f = out_flit[o];
      check_idle($sformatf("out_valid under ack ch%0d", o), 1'b1, out_valid[o]);
      if (owner[o] < 0) owner[o] = int'(f.data[6:4]);  // head names its source
      src = owner[o];
      if (exp_q[src].size() == 0) begin
         fail_run($sformatf("output %0d delivered a flit that no source was sending", o));
      end
      e = exp_q[src].pop_front();
      check_flit($sformatf("flit src%0d out%0d", src, o), e, f);
      check_port($sformatf("port src%0d out%0d", src, o), owner_port[o], port_id_t'(o / N_SUBC));
      if (f.eof) begin
         owner[o] = -1;                                // frame done, output free in model
         rcvd_frames++;
      end
   endtask

   task automatic monitor_outputs();
      for (int o = 0; o < N_CHAN; o++) begin
         if (prev_hold[o]) begin                       // no ack yet, so nothing may move
            check_idle($sformatf("out_valid hold ch%0d", o), 1'b1, out_valid[o]);
            check_flit($sformatf("out_flit hold ch%0d", o), prev_flit[o], out_flit[o]);
         end
         if (owner[o] < 0 && out_valid[o] && tx_q[out_flit[o].data[6:4]].size() > 0) begin
            owner_port[o] = port_id_t'(tx_q[out_flit[o].data[6:4]][0].data[DEST_W-1:0]);
         end
         ack_nxt[o] = 1'b0;
         if (out_ack[o]) begin
            accept_flit(o);
            armed[o] = 1'b0;
         end else if (out_valid[o]) begin
            if (!armed[o]) begin                       // new flit, pick its ack delay
               armed[o]    = 1'b1;
               wait_cnt[o] = rnd(4);
            end
            if (wait_cnt[o] == 0) ack_nxt[o] = 1'b1;
            else wait_cnt[o]--;
         end
         prev_hold[o] = out_valid[o] && !out_ack[o];
         prev_flit[o] = out_flit[o];
      end
   endtask

   task automatic track_senders();
      for (int c = 0; c < N_CHAN; c++) begin
         if (in_ack[c]) begin
            check_idle($sformatf("in_valid under in_ack ch%0d", c), 1'b1, in_valid[c]);
            check_idle($sformatf("in_ack pulse ch%0d", c), 1'b0, last_in_ack[c]);
            void'(tx_q[c].pop_front());                // flit taken, offer the next one
         end
         last_in_ack[c] = in_ack[c];
         if (tx_q[c].size() == 0 && frames_left[c] > 0) begin
            if (gap[c] > 0) begin
               gap[c]--;
            end else begin
               make_frame(c);
               frames_left[c]--;
               gap[c] = rnd(3);
            end
         end
         valid_nxt[c] = (tx_q[c].size() > 0);
         flit_nxt[c]  = valid_nxt[c] ? tx_q[c][0] : '0;
      end
   endtask

   function automatic logic all_done();
      logic done;
      done = (in_valid == '0) && (rcvd_frames == sent_frames);
      for (int c = 0; c < N_CHAN; c++) begin
         if (frames_left[c] > 0 || tx_q[c].size() > 0 || exp_q[c].size() > 0) done = 1'b0;
         if (owner[c] >= 0) done = 1'b0;
      end
      return done;
   endfunction

   initial begin
      #(LIMIT_CYC * 10);
      fail_run("watchdog fired because traffic never drained and the run hung");
   end

   initial begin
      rst_n    = 1'b0;
      in_flit  = '0;
      in_valid = '0;
      out_ack  = '0;
      for (int c = 0; c < N_CHAN; c++) begin
         frames_left[c] = N_FRAMES;
         gap[c]         = c % 3;                        // stagger the first heads
         seq[c]         = '0;
         owner[c]       = -1;
         owner_port[c]  = '0;
         wait_cnt[c]    = 0;
         armed[c]       = 1'b0;
         prev_hold[c]   = 1'b0;
         prev_flit[c]   = '0;
         last_in_ack[c] = 1'b0;
      end
      repeat (3) @(posedge clk);
      #1;
      rst_n = 1'b1;

      @(negedge clk);
      for (int c = 0; c < N_CHAN; c++) begin
         check_idle($sformatf("out_valid after reset ch%0d", c), 1'b0, out_valid[c]);
         check_idle($sformatf("in_ack after reset ch%0d", c), 1'b0, in_ack[c]);
      end

      while (!all_done()) begin
         @(negedge clk);                                // outputs settled here
         monitor_outputs();
         track_senders();
         @(posedge clk);
         #1;
         out_ack  = ack_nxt;
         in_valid = valid_nxt;
         in_flit  = flit_nxt;
      end

      repeat (2) @(negedge clk);
      for (int c = 0; c < N_CHAN; c++) begin
         check_idle($sformatf("out_valid at end ch%0d", c), 1'b0, out_valid[c]);
         check_idle($sformatf("in_ack at end ch%0d", c), 1'b0, in_ack[c]);
      end
      $display("%0d valid frames delivered", rcvd_frames);
      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule : tb_sdm_router

`default_nettype wire

// File: tb.f
source/flit_pkg.sv
source/router_pkg.sv
source/route_decode.sv
source/subc_ctl.sv
source/switch_alloc.sv
source/crossbar.sv
source/sdm_router.sv
tests/tb_sdm_router.sv

// File: run.sh
#!/bin/sh
# build the sdm router testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --top-module tb_sdm_router -f tb.f

out=$(./obj_dir/Vtb_sdm_router 2>&1) || true
echo "$out"

# pass only when the testbench printed its pass line
echo "$out" | grep -qF '*** TEST PASSED ***'
